// File: Makefile
VERILATOR  ?= verilator
TOP        ?= dcache_subsystem_tb
RTL_TOP    ?= dcache_subsystem
FILELIST   ?= dcache_subsystem.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: dcache_subsystem.f
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_array.sv
logic/miss_fifo.sv
logic/miss_control.sv
logic/dcache_subsystem.sv
tb/mem_responder.sv
tb/dcache_subsystem_tb.sv

// File: logic/dcache_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module dcache_array (
    input  logic                            clock,
    input  logic                            reset,
    input  dcache_pkg::line_req_t [1:0]     read_reqs,
    output dcache_pkg::read_result_t [1:0]  read_results,
    input  dcache_pkg::store_write_t        store_write,
    output logic                            store_hit,
    input  dcache_pkg::line_req_t           refill,
    input  dcache_pkg::block_t              refill_data,
    output dcache_pkg::writeback_t          victim
);

    localparam int LINES      = `DCACHE_LINES;
    localparam int INDEX_BITS = $clog2(LINES);

    dcache_pkg::cache_line_t      lines [LINES];
    logic [1:0][LINES-1:0]        read_match;
    logic [LINES-1:0]             store_match;
    logic [LINES-1:0]             refill_match;
    logic [INDEX_BITS-1:0]        store_index;
    logic [INDEX_BITS-1:0]        free_index;
    logic                         free_found;
    logic [INDEX_BITS-1:0]        victim_ptr;
    logic [LINES-1:0]             write_mask;
    dcache_pkg::cache_line_t      write_line;
    dcache_pkg::block_t           merged_data;

    // Both load ports search every line in parallel
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            read_results[p] = '0;
            for (int i = 0; i < LINES; i++) begin
                read_match[p][i] = read_reqs[p].valid && lines[i].valid &&
                                   (lines[i].block == read_reqs[p].block);
                if (read_match[p][i]) begin
                    read_results[p].valid = 1'b1;
                    read_results[p].data  = lines[i].data;
                end
            end
        end
    end

    always_comb begin
        store_index = '0;
        for (int i = 0; i < LINES; i++) begin
            store_match[i] = store_write.valid && lines[i].valid &&
                             (lines[i].block == store_write.block);
            if (store_match[i]) begin
                store_index = INDEX_BITS'(i);
            end
        end
    end

    assign store_hit = |store_match;

    // Lines that already hold the block being refilled
    always_comb begin
        for (int i = 0; i < LINES; i++) begin
            refill_match[i] = lines[i].valid && (lines[i].block == refill.block);
        end
    end

    // Scan downwards so the lowest free line wins
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = LINES - 1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                free_found = 1'b1;
                free_index = INDEX_BITS'(i);
            end
        end
    end

    always_comb begin
        write_mask = '0;
        write_line = '0;
        victim     = '0;

        merged_data = lines[store_index].data;
        for (int b = 0; b < `DCACHE_BLOCK_BYTES; b++) begin
            if (store_write.byte_en[b]) begin
                merged_data.byte_level[b] = store_write.data.byte_level[b];
            end
        end

        if (refill.valid) begin
            // Refilled line arrives clean
            write_line.valid = 1'b1;
            write_line.block = refill.block;
            write_line.data  = refill_data;
            if (free_found) begin
                write_mask[free_index] = 1'b1;
            end else begin
                write_mask[victim_ptr] = 1'b1;
                // Only a dirty victim goes back to memory
                victim.valid = lines[victim_ptr].dirty;
                victim.block = lines[victim_ptr].block;
                victim.data  = lines[victim_ptr].data;
            end
        end else if (store_hit) begin
            write_mask[store_index] = 1'b1;
            write_line       = lines[store_index];
            write_line.dirty = 1'b1;
            write_line.data  = merged_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            victim_ptr <= '0;
            for (int i = 0; i < LINES; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else begin
            for (int i = 0; i < LINES; i++) begin
                if (write_mask[i]) begin
                    lines[i] <= write_line;
                end
            end
            // Round robin pointer moves on every eviction
            if (refill.valid && !free_found) begin
                victim_ptr <= (victim_ptr == INDEX_BITS'(LINES - 1)) ? '0 : victim_ptr + 1'b1;
            end
        end
    end

    // Relies on the miss FIFO never requesting a block twice
    a_single_match: assert property (@(posedge clock) disable iff (!reset)
        $onehot0(read_match[0]) && $onehot0(read_match[1]) && $onehot0(store_match));

    // A refill never places a block that some line already holds
    a_single_write: assert property (@(posedge clock) disable iff (!reset)
        refill.valid |-> (refill_match == '0));

endmodule

`default_nettype wire

// File: logic/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry
`define DCACHE_LINES 8
`define DCACHE_BLOCK_BYTES 8

// Byte offset inside a line, address bits 2 to 0
`define DCACHE_OFFSET_BITS 3

// Block number, address bits 31 to 3
`define DCACHE_BLOCK_TAG_BITS 29

// Outstanding misses tracked in order
`define DCACHE_MISS_DEPTH 4

// Memory transaction tag, zero means no transaction
`define DCACHE_MEM_TAG_BITS 4

`endif

// File: logic/dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    // One line of data, seen as bytes or as 32-bit words
    typedef union packed {
        logic [`DCACHE_BLOCK_BYTES-1:0][7:0] byte_level;
        logic [1:0][31:0]                    word_level;
    } block_t;

    typedef logic [`DCACHE_BLOCK_TAG_BITS-1:0] block_tag_t;
    typedef logic [`DCACHE_MEM_TAG_BITS-1:0]   mem_tag_t;

    typedef struct packed {
        logic       valid;
        block_tag_t block;
    } line_req_t;

    // Valid means the lookup hit
    typedef struct packed {
        logic   valid;
        block_t data;
    } read_result_t;

    typedef struct packed {
        logic       valid;
        logic       dirty;
        block_tag_t block;
        block_t     data;
    } cache_line_t;

    // Store data already sits in its word lane
    typedef struct packed {
        logic                           valid;
        block_tag_t                     block;
        block_t                         data;
        logic [`DCACHE_BLOCK_BYTES-1:0] byte_en;
    } store_write_t;

    typedef struct packed {
        logic       valid;
        mem_tag_t   mem_tag;
        block_tag_t block;
    } miss_entry_t;

    typedef struct packed {
        logic       valid;
        block_tag_t block;
        block_t     data;
    } writeback_t;

endpackage

`default_nettype wire

// File: logic/dcache_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_subsystem (
    input  logic                            clock,
    input  logic                            reset,

    // Load lookups, index 0 is the older load
    input  dcache_pkg::line_req_t [1:0]     read_reqs,
    output dcache_pkg::read_result_t [1:0]  read_results,

    // Word stores
    input  logic                            store_valid,
    input  logic [31:0]                     store_addr,
    input  logic [31:0]                     store_data,
    output logic                            store_done,

    // Memory side
    output dcache_pkg::line_req_t           mem_req,
    input  logic                            mem_req_accepted,
    input  dcache_pkg::mem_tag_t            current_req_tag,
    input  dcache_pkg::block_t              mem_data,
    input  dcache_pkg::mem_tag_t            mem_data_tag,
    output dcache_pkg::writeback_t          mem_write
);

    dcache_pkg::store_write_t  store_write;
    logic                      store_hit;
    dcache_pkg::line_req_t     refill;
    dcache_pkg::writeback_t    victim;
    dcache_pkg::block_tag_t    snoop_block;
    logic                      miss_pending;
    logic                      fifo_full;
    dcache_pkg::miss_entry_t   new_entry;

    dcache_array u_array (
        .clock        (clock),
        .reset        (reset),
        .read_reqs    (read_reqs),
        .read_results (read_results),
        .store_write  (store_write),
        .store_hit    (store_hit),
        .refill       (refill),
        .refill_data  (mem_data),
        .victim       (victim)
    );

    miss_fifo u_miss_fifo (
        .clock        (clock),
        .reset        (reset),
        .snoop_block  (snoop_block),
        .miss_pending (miss_pending),
        .full         (fifo_full),
        .new_entry    (new_entry),
        .mem_data_tag (mem_data_tag),
        .refill       (refill)
    );

    miss_control u_miss_control (
        .store_valid      (store_valid),
        .store_addr       (store_addr),
        .store_data       (store_data),
        .store_done       (store_done),
        .store_write      (store_write),
        .store_hit        (store_hit),
        .read_reqs        (read_reqs),
        .read_results     (read_results),
        .refill_active    (refill.valid),
        .victim           (victim),
        .mem_write        (mem_write),
        .miss_pending     (miss_pending),
        .fifo_full        (fifo_full),
        .snoop_block      (snoop_block),
        .mem_req          (mem_req),
        .mem_req_accepted (mem_req_accepted),
        .current_req_tag  (current_req_tag),
        .new_entry        (new_entry)
    );

endmodule

`default_nettype wire

// File: logic/miss_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module miss_control (
    input  logic                            store_valid,
    input  logic [31:0]                     store_addr,
    input  logic [31:0]                     store_data,
    output logic                            store_done,
    output dcache_pkg::store_write_t        store_write,
    input  logic                            store_hit,
    input  dcache_pkg::line_req_t [1:0]     read_reqs,
    input  dcache_pkg::read_result_t [1:0]  read_results,
    input  logic                            refill_active,
    input  dcache_pkg::writeback_t          victim,
    output dcache_pkg::writeback_t          mem_write,
    input  logic                            miss_pending,
    input  logic                            fifo_full,
    output dcache_pkg::block_tag_t          snoop_block,
    output dcache_pkg::line_req_t           mem_req,
    input  logic                            mem_req_accepted,
    input  dcache_pkg::mem_tag_t            current_req_tag,
    output dcache_pkg::miss_entry_t         new_entry
);

    localparam int WORD_BIT = `DCACHE_OFFSET_BITS - 1;

    dcache_pkg::line_req_t oldest_miss;

    // Word store, placed in the lane picked by address bit 2
    always_comb begin
        store_write       = '0;
        store_write.valid = store_valid;
        store_write.block = store_addr[31:`DCACHE_OFFSET_BITS];
        if (store_addr[WORD_BIT]) begin
            store_write.data.word_level[1] = store_data;
            store_write.byte_en            = 8'b1111_0000;
        end else begin
            store_write.data.word_level[0] = store_data;
            store_write.byte_en            = 8'b0000_1111;
        end
    end

    // The array gives the refill the write port in its cycle
    assign store_done = store_valid && store_hit && !refill_active;

    // Store miss first, then the older load
    always_comb begin
        oldest_miss = '0;
        if (store_valid && !store_hit) begin
            oldest_miss.valid = 1'b1;
            oldest_miss.block = store_write.block;
        end else if (read_reqs[0].valid && !read_results[0].valid) begin
            oldest_miss = read_reqs[0];
        end else if (read_reqs[1].valid && !read_results[1].valid) begin
            oldest_miss = read_reqs[1];
        end
    end

    assign snoop_block = oldest_miss.block;

    // Victim already carries valid only for dirty lines
    assign mem_write = victim;

    always_comb begin
        mem_req       = '0;
        mem_req.block = oldest_miss.block;
        mem_req.valid = oldest_miss.valid && !victim.valid && !miss_pending && !fifo_full;
    end

    always_comb begin
        new_entry         = '0;
        new_entry.valid   = mem_req.valid && mem_req_accepted && (current_req_tag != '0);
        new_entry.mem_tag = current_req_tag;
        new_entry.block   = mem_req.block;
    end

endmodule

`default_nettype wire

// File: logic/miss_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_config.svh"

module miss_fifo (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::block_tag_t   snoop_block,
    output logic                     miss_pending,
    output logic                     full,
    input  dcache_pkg::miss_entry_t  new_entry,
    input  dcache_pkg::mem_tag_t     mem_data_tag,
    output dcache_pkg::line_req_t    refill
);

    localparam int DEPTH    = `DCACHE_MISS_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    dcache_pkg::miss_entry_t  entries [DEPTH];
    logic [PTR_BITS-1:0]      head;
    logic [PTR_BITS-1:0]      tail;
    logic                     pop;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        next_ptr = (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Any outstanding request for this block counts, not only the head
    always_comb begin
        miss_pending = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (entries[i].valid && (entries[i].block == snoop_block)) begin
                miss_pending = 1'b1;
            end
        end
    end

    // Tail slot still occupied means every slot is in use
    assign full = entries[tail].valid;

    // Memory answers in order, so a returned tag belongs to the head
    assign pop = (mem_data_tag != '0) && entries[head].valid &&
                 (entries[head].mem_tag == mem_data_tag);

    always_comb begin
        refill       = '0;
        refill.valid = pop;
        refill.block = entries[head].block;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head <= next_ptr(head);
            end
            if (new_entry.valid) begin
                entries[tail] <= new_entry;
                tail <= next_ptr(tail);
            end
        end
    end

    // Request side must hold off while full
    a_no_push_full: assert property (@(posedge clock) disable iff (!reset)
        new_entry.valid |-> !full);

    // Out of order returns would lose a refill
    a_return_in_order: assert property (@(posedge clock) disable iff (!reset)
        (mem_data_tag != '0) |-> pop);

endmodule

`default_nettype wire

// File: tb/dcache_subsystem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_subsystem_tb;

    localparam int          TIMEOUT = 40;
    localparam logic [31:0] NONE    = 32'h0;

    typedef enum logic [1:0] {OP_IDLE, OP_LOAD, OP_PAIR, OP_STORE} op_t;

    // A zero writeback address means the step evicts nothing dirty
    typedef struct packed {
        op_t         op;
        logic [31:0] addr0;
        logic [31:0] addr1;
        logic [31:0] data;
        logic        first_hit;
        logic [1:0]  reads;
        logic [31:0] wb_addr;
    } step_t;

    logic                            clock;
    logic                            reset;
    dcache_pkg::line_req_t [1:0]     read_reqs;
    dcache_pkg::read_result_t [1:0]  read_results;
    logic                            store_valid;
    logic [31:0]                     store_addr;
    logic [31:0]                     store_data;
    logic                            store_done;
    dcache_pkg::line_req_t           mem_req;
    logic                            mem_req_accepted;
    dcache_pkg::mem_tag_t            current_req_tag;
    dcache_pkg::block_t              mem_data;
    dcache_pkg::mem_tag_t            mem_data_tag;
    dcache_pkg::writeback_t          mem_write;
    int                              read_count;
    int                              write_count;
    dcache_pkg::writeback_t          last_write;

    step_t               steps [$];
    dcache_pkg::block_t  stored_blocks [dcache_pkg::block_tag_t];
    int                  step_errors;

    dcache_subsystem dut (.*);

    mem_responder #(.SEED(32'he275)) memory (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] blk_addr(input int k);
        return 32'h0000_1000 + 32'(k * 64);
    endfunction

    // Memory pattern of the block, replaced once a store has touched it
    function automatic dcache_pkg::block_t expected_block(input logic [31:0] addr);
        dcache_pkg::block_t data;
        data.word_level[0] = {3'b000, addr[31:3]} ^ 32'ha5a5_0000;
        data.word_level[1] = {addr[31:3], 3'b101} ^ 32'h0f0f_f0f0;
        if (stored_blocks.exists(addr[31:3])) begin
            data = stored_blocks[addr[31:3]];
        end
        return data;
    endfunction

    task automatic add_step(input op_t op, input logic [31:0] addr0, input logic [31:0] addr1,
                            input logic [31:0] data, input logic first_hit,
                            input logic [1:0] reads, input logic [31:0] wb_addr);
        step_t step;
        step.op        = op;
        step.addr0     = addr0;
        step.addr1     = addr1;
        step.data      = data;
        step.first_hit = first_hit;
        step.reads     = reads;
        step.wb_addr   = wb_addr;
        steps.push_back(step);
    endtask

    task automatic fill_table();
        add_step(OP_LOAD,  blk_addr(0),     NONE,        NONE,          1'b0, 2'd1, NONE);
        add_step(OP_LOAD,  blk_addr(0),     NONE,        NONE,          1'b1, 2'd0, NONE);
        add_step(OP_LOAD,  blk_addr(1),     NONE,        NONE,          1'b0, 2'd1, NONE);
        add_step(OP_PAIR,  blk_addr(0),     blk_addr(1), NONE,          1'b1, 2'd0, NONE);
        add_step(OP_STORE, blk_addr(0),     NONE,        32'h1111_1111, 1'b1, 2'd0, NONE);
        add_step(OP_LOAD,  blk_addr(0),     NONE,        NONE,          1'b1, 2'd0, NONE);
        add_step(OP_STORE, blk_addr(0) + 4, NONE,        32'h2222_2222, 1'b1, 2'd0, NONE);
        add_step(OP_LOAD,  blk_addr(0),     NONE,        NONE,          1'b1, 2'd0, NONE);
        // Store miss holds until its refill lands
        add_step(OP_STORE, blk_addr(2) + 4, NONE,        32'h3333_3333, 1'b0, 2'd1, NONE);
        add_step(OP_IDLE,  NONE,            NONE,        NONE,          1'b1, 2'd0, NONE);
        add_step(OP_LOAD,  blk_addr(2),     NONE,        NONE,          1'b1, 2'd0, NONE);
        // Same absent block on both ports
        add_step(OP_PAIR,  blk_addr(3),     blk_addr(3), NONE,          1'b0, 2'd1, NONE);
        add_step(OP_LOAD,  blk_addr(4),     NONE,        NONE,          1'b0, 2'd1, NONE);
        add_step(OP_LOAD,  blk_addr(5),     NONE,        NONE,          1'b0, 2'd1, NONE);
        add_step(OP_STORE, blk_addr(6),     NONE,        32'h4444_4444, 1'b0, 2'd1, NONE);
        add_step(OP_LOAD,  blk_addr(7),     NONE,        NONE,          1'b0, 2'd1, NONE);
        // Cache full, victims taken from line 0 upwards
        add_step(OP_LOAD,  blk_addr(8),     NONE,        NONE,          1'b0, 2'd1, blk_addr(0));
        add_step(OP_LOAD,  blk_addr(9),     NONE,        NONE,          1'b0, 2'd1, NONE);
        add_step(OP_LOAD,  blk_addr(10),    NONE,        NONE,          1'b0, 2'd1, blk_addr(2));
        add_step(OP_PAIR,  blk_addr(11),    blk_addr(12), NONE,         1'b0, 2'd2, NONE);
        add_step(OP_PAIR,  blk_addr(8),     blk_addr(6), NONE,          1'b1, 2'd0, NONE);
    endtask

    task automatic apply_step(input step_t step);
        read_reqs  = '0;
        store_addr = step.addr0;
        store_data = step.data;
        if (step.op == OP_LOAD || step.op == OP_PAIR) begin
            read_reqs[0].valid = 1'b1;
            read_reqs[0].block = step.addr0[31:3];
        end
        if (step.op == OP_PAIR) begin
            read_reqs[1].valid = 1'b1;
            read_reqs[1].block = step.addr1[31:3];
        end
        store_valid = (step.op == OP_STORE);
    endtask

    task automatic expect_true(input logic ok, input string what);
        assert (ok) else begin
            $display("MISMATCH at %0t ns: %s", $time, what);
            step_errors++;
        end
    endtask

    initial begin
        int                  cycles;
        int                  reads_before;
        int                  writes_before;
        int                  errors;
        int                  passed;
        int                  failed;
        logic                done;
        logic                first_done;
        logic                timed_out;
        dcache_pkg::block_t  exp;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        timed_out   = 1'b0;
        reset       = 1'b0;
        read_reqs   = '0;
        store_valid = 1'b0;
        store_addr  = '0;
        store_data  = '0;
        fill_table();
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            step_errors   = 0;
            reads_before  = read_count;
            writes_before = write_count;
            cycles        = 0;
            done          = 1'b0;
            first_done    = 1'b0;
            while (!done && cycles < TIMEOUT) begin
                @(negedge clock);
                apply_step(steps[i]);
                #1;
                case (steps[i].op)
                    OP_LOAD:  done = read_results[0].valid;
                    OP_PAIR:  done = read_results[0].valid && read_results[1].valid;
                    OP_STORE: done = store_done;
                    default:  done = 1'b1;
                endcase
                if (cycles == 0) begin
                    first_done = done;
                end
                cycles++;
            end
            if (!done) begin
                $display("Timeout: step %0d did not complete within %0d cycles", i, TIMEOUT);
                timed_out = 1'b1;
                failed++;
                break;
            end
            expect_true(first_done == steps[i].first_hit,
                $sformatf("step %0d first cycle done %0b, expected %0b",
                          i, first_done, steps[i].first_hit));
            expect_true(read_count - reads_before == int'(steps[i].reads),
                $sformatf("step %0d sent %0d read requests, expected %0d",
                          i, read_count - reads_before, steps[i].reads));
            expect_true(write_count - writes_before == ((steps[i].wb_addr != NONE) ? 1 : 0),
                $sformatf("step %0d produced %0d writebacks", i, write_count - writes_before));
            if (steps[i].wb_addr != NONE) begin
                exp = expected_block(steps[i].wb_addr);
                expect_true(last_write.block == steps[i].wb_addr[31:3] && last_write.data == exp,
                    $sformatf("step %0d writeback %h:%h, expected %h:%h", i, last_write.block,
                              last_write.data, steps[i].wb_addr[31:3], exp));
            end
            if (steps[i].op == OP_LOAD || steps[i].op == OP_PAIR) begin
                exp = expected_block(steps[i].addr0);
                expect_true(read_results[0].data == exp,
                    $sformatf("step %0d port 0 data %h, expected %h", i, read_results[0].data, exp));
            end
            if (steps[i].op == OP_PAIR) begin
                exp = expected_block(steps[i].addr1);
                expect_true(read_results[1].data == exp,
                    $sformatf("step %0d port 1 data %h, expected %h", i, read_results[1].data, exp));
            end
            // Word lane comes from address bit 2
            if (steps[i].op == OP_STORE) begin
                exp = expected_block(steps[i].addr0);
                exp.word_level[steps[i].addr0[2]] = steps[i].data;
                stored_blocks[steps[i].addr0[31:3]] = exp;
            end
            errors += step_errors;
            if (step_errors == 0) begin
                passed++;
            end else begin
                failed++;
            end
            $display("step %0d %s: %s", i, steps[i].op.name(), (step_errors == 0) ? "ok" : "FAIL");
        end
        $display("%0d steps passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mem_responder.sv
`timescale 1ns/1ns
`default_nettype none

module mem_responder #(
    parameter logic [31:0] SEED         = 32'h1,
    parameter int          SAMPLE_DELAY = 3
) (
    input  logic                    clock,
    input  dcache_pkg::line_req_t   mem_req,
    output logic                    mem_req_accepted,
    output dcache_pkg::mem_tag_t    current_req_tag,
    output dcache_pkg::block_t      mem_data,
    output dcache_pkg::mem_tag_t    mem_data_tag,
    input  dcache_pkg::writeback_t  mem_write,
    output int                      read_count,
    output int                      write_count,
    output dcache_pkg::writeback_t  last_write
);

    dcache_pkg::mem_tag_t    next_tag;
    dcache_pkg::mem_tag_t    pend_tags [$];
    dcache_pkg::block_tag_t  pend_blocks [$];
    int                      pend_due [$];
    int                      cycle;
    logic                    taken;

    // Every request is taken in the cycle it shows up
    assign mem_req_accepted = mem_req.valid;
    assign current_req_tag  = next_tag;

    function automatic dcache_pkg::block_t block_pattern(input dcache_pkg::block_tag_t block);
        dcache_pkg::block_t data;
        data.word_level[0] = {3'b000, block} ^ 32'ha5a5_0000;
        data.word_level[1] = {block, 3'b101} ^ 32'h0f0f_f0f0;
        return data;
    endfunction

    initial begin
        void'($urandom(SEED));
        next_tag     = dcache_pkg::mem_tag_t'(1);
        mem_data     = '0;
        mem_data_tag = '0;
        read_count   = 0;
        write_count  = 0;
        last_write   = '0;
        cycle        = 0;
        taken        = 1'b0;
        forever begin
            @(negedge clock);
            cycle++;
            // Tags run 1 to 15, zero is never used
            if (taken) begin
                next_tag = (next_tag == '1) ? dcache_pkg::mem_tag_t'(1) : next_tag + 1'b1;
                taken    = 1'b0;
            end
            mem_data_tag = '0;
            if (pend_due.size() > 0 && cycle >= pend_due[0]) begin
                mem_data_tag = pend_tags.pop_front();
                mem_data     = block_pattern(pend_blocks.pop_front());
                void'(pend_due.pop_front());
            end
            // Look at the request side just before the rising edge
            #(SAMPLE_DELAY);
            if (mem_req.valid) begin
                pend_tags.push_back(next_tag);
                pend_blocks.push_back(mem_req.block);
                pend_due.push_back(cycle + 3 + int'($urandom % 4));
                read_count++;
                taken = 1'b1;
            end
            if (mem_write.valid) begin
                write_count++;
                last_write = mem_write;
            end
        end
    end

endmodule

`default_nettype wire
